// ==== logic/rv_pkg.sv ====
package rv_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [4:0]      reg_addr_t;

	// Major opcodes of the supported instruction classes
	localparam logic [6:0] OPC_R = 7'b0110011;
	localparam logic [6:0] OPC_I = 7'b0010011;
	localparam logic [6:0] OPC_L = 7'b0000011;
	localparam logic [6:0] OPC_S = 7'b0100011;
	localparam logic [6:0] OPC_B = 7'b1100011;
	localparam logic [6:0] OPC_U = 7'b0110111; // LUI
	localparam logic [6:0] OPC_J = 7'b1101111; // JAL

	localparam logic [6:0] FUNCT7_ALT = 7'b0100000; // Selects sub and sra

	// Access size encodings in funct3 of loads and stores
	localparam logic [2:0] F3_B  = 3'b000;
	localparam logic [2:0] F3_H  = 3'b001;
	localparam logic [2:0] F3_W  = 3'b010;
	localparam logic [2:0] F3_BU = 3'b100;
	localparam logic [2:0] F3_HU = 3'b101;

	// Branch conditions in funct3 of branches
	localparam logic [2:0] BR_EQ  = 3'b000;
	localparam logic [2:0] BR_NE  = 3'b001;
	localparam logic [2:0] BR_LT  = 3'b100;
	localparam logic [2:0] BR_GE  = 3'b101;
	localparam logic [2:0] BR_LTU = 3'b110;
	localparam logic [2:0] BR_GEU = 3'b111;

	localparam int DMEM_BYTES = 1024;
	localparam int DMEM_WORDS = 256;
	localparam int DMEM_AW    = $clog2(DMEM_BYTES); // Byte address bits in use

	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SLL    = 4'd1,
		ALU_SLT    = 4'd2,
		ALU_SLTU   = 4'd3,
		ALU_XOR    = 4'd4,
		ALU_SRL    = 4'd5,
		ALU_SRA    = 4'd6,
		ALU_OR     = 4'd7,
		ALU_AND    = 4'd8,
		ALU_SUB    = 4'd9,
		ALU_PASS_B = 4'd10 // LUI
	} alu_op_t;

	typedef enum logic [1:0] {
		WB_ALU = 2'd0,
		WB_MEM = 2'd1,
		WB_PC4 = 2'd2
	} wb_sel_t;

	typedef struct packed {
		logic       reg_wr;
		logic       sel_a;     // 1 takes rs1, 0 takes pc
		logic       sel_b;     // 1 takes imm, 0 takes rs2
		logic       rd_en;     // Load
		logic       wr_en;     // Store
		wb_sel_t    wb_sel;
		alu_op_t    alu_op;
		logic [2:0] mask;
		logic [2:0] br_type;
		logic       is_branch;
		logic       is_jump;
		word_t      imm;
	} ctrl_t;

	typedef struct packed {
		logic      valid;
		word_t     pc;
		logic      rd_we;
		reg_addr_t rd;
		word_t     data;
	} retire_t;

endpackage

// ==== logic/rv_decoder.sv ====
`timescale 1ns/1ns

module rv_decoder import rv_pkg::*; (
	input  word_t instr,
	output ctrl_t ctrl
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       alt;
	logic       is_r;
	alu_op_t    arith_op;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_u;
	word_t      imm_j;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign alt    = (instr[31:25] == FUNCT7_ALT);
	assign is_r   = (opcode == OPC_R);

	// Immediate formats
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// Shared by R and I type where only R type has sub
	always_comb begin
		case (funct3)
			3'b000:  arith_op = (is_r && alt) ? ALU_SUB : ALU_ADD;
			3'b001:  arith_op = ALU_SLL;
			3'b010:  arith_op = ALU_SLT;
			3'b011:  arith_op = ALU_SLTU;
			3'b100:  arith_op = ALU_XOR;
			3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;
			3'b110:  arith_op = ALU_OR;
			default: arith_op = ALU_AND;
		endcase
	end

	always_comb begin
		ctrl = '0; // Unknown opcodes only advance the pc
		case (opcode)
			OPC_R, OPC_I: begin
				ctrl.reg_wr = 1'b1;
				ctrl.sel_a  = 1'b1;
				ctrl.sel_b  = !is_r;
				ctrl.alu_op = arith_op;
				ctrl.imm    = imm_i;
			end
			OPC_U: begin
				ctrl.reg_wr = 1'b1;
				ctrl.sel_b  = 1'b1;
				ctrl.alu_op = ALU_PASS_B;
				ctrl.imm    = imm_u;
			end
			OPC_L: begin
				if (funct3 inside {F3_B, F3_H, F3_W, F3_BU, F3_HU}) begin
					ctrl.reg_wr = 1'b1;
					ctrl.sel_a  = 1'b1;
					ctrl.sel_b  = 1'b1;
					ctrl.rd_en  = 1'b1;
					ctrl.wb_sel = WB_MEM;
					ctrl.mask   = funct3;
					ctrl.imm    = imm_i;
				end
			end
			OPC_S: begin
				if (funct3 inside {F3_B, F3_H, F3_W}) begin
					ctrl.sel_a = 1'b1;
					ctrl.sel_b = 1'b1;
					ctrl.wr_en = 1'b1;
					ctrl.mask  = funct3;
					ctrl.imm   = imm_s;
				end
			end
			OPC_B: begin
				ctrl.sel_b     = 1'b1; // pc + imm on the ALU
				ctrl.is_branch = 1'b1;
				ctrl.br_type   = funct3;
				ctrl.imm       = imm_b;
			end
			OPC_J: begin
				ctrl.reg_wr  = 1'b1;
				ctrl.sel_b   = 1'b1;
				ctrl.wb_sel  = WB_PC4; // Link value
				ctrl.is_jump = 1'b1;
				ctrl.imm     = imm_j;
			end
			default: ;
		endcase
	end

	// Memory access and control transfer are exclusive
	always_comb begin
		assert (!((ctrl.rd_en || ctrl.wr_en) && (ctrl.is_branch || ctrl.is_jump)))
			else $error("decoder: memory access combined with branch or jump");
	end

endmodule

// ==== logic/rv_alu.sv ====
`timescale 1ns/1ns

module rv_alu import rv_pkg::*; (
	input  ctrl_t ctrl,
	input  word_t rs1_data,
	input  word_t rs2_data,
	input  word_t pc,
	output word_t alu_result
);

	word_t      op_a;
	word_t      op_b;
	logic [4:0] shamt;

	assign op_a  = ctrl.sel_a ? rs1_data : pc;
	assign op_b  = ctrl.sel_b ? ctrl.imm : rs2_data;
	assign shamt = op_b[4:0]; // Only the low bits count for shifts

	always_comb begin
		case (ctrl.alu_op)
			ALU_ADD: alu_result = op_a + op_b; // Also load and store address
			ALU_SUB: alu_result = op_a - op_b;
			ALU_SLL: alu_result = op_a << shamt;
			ALU_SRL: alu_result = op_a >> shamt;
			ALU_SRA: alu_result = word_t'($signed(op_a) >>> shamt);
			ALU_SLT: begin
				alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
			end
			ALU_SLTU: begin
				alu_result = {31'b0, op_a < op_b};
			end
			ALU_XOR:    alu_result = op_a ^ op_b;
			ALU_OR:     alu_result = op_a | op_b;
			ALU_AND:    alu_result = op_a & op_b;
			ALU_PASS_B: alu_result = op_b;
			default:    alu_result = '0;
		endcase
	end

endmodule

// ==== logic/rv_pc_unit.sv ====
`timescale 1ns/1ns

module rv_pc_unit import rv_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  instr_valid,
	input  ctrl_t ctrl,
	input  word_t rs1_data,
	input  word_t rs2_data,
	output word_t pc
);

	logic  cond;
	logic  taken;
	word_t next_pc;

	always_comb begin
		case (ctrl.br_type)
			BR_EQ:   cond = (rs1_data == rs2_data);
			BR_NE:   cond = (rs1_data != rs2_data);
			BR_LT:   cond = ($signed(rs1_data) < $signed(rs2_data));
			BR_GE:   cond = ($signed(rs1_data) >= $signed(rs2_data));
			BR_LTU:  cond = (rs1_data < rs2_data);
			BR_GEU:  cond = (rs1_data >= rs2_data);
			default: cond = 1'b0; // Reserved funct3 falls through
		endcase
	end

	assign taken   = (ctrl.is_branch && cond) || ctrl.is_jump;
	assign next_pc = taken ? pc + ctrl.imm : pc + 32'd4;

	always_ff @(posedge clk) begin
		if (reset)
			pc <= '0;
		else if (instr_valid)
			pc <= next_pc;
	end

	// Targets come from the decoder immediates
	a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
		else $error("pc_unit: pc not word aligned");

endmodule

// ==== logic/rv_regfile.sv ====
`timescale 1ns/1ns

module rv_regfile import rv_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    instr_valid,
	input  word_t   instr,
	input  ctrl_t   ctrl,
	input  word_t   alu_result,
	input  word_t   load_data,
	input  word_t   pc,
	output word_t   rs1_data,
	output word_t   rs2_data,
	output retire_t retire
);

	word_t     regs [32];
	reg_addr_t rd;
	logic      rd_we;
	word_t     wb_data;

	assign rd       = instr[11:7];
	assign rs1_data = regs[instr[19:15]];
	assign rs2_data = regs[instr[24:20]];
	assign rd_we    = ctrl.reg_wr && (rd != '0); // x0 is never written

	always_comb begin
		case (ctrl.wb_sel)
			WB_MEM:  wb_data = load_data;
			WB_PC4:  wb_data = pc + 32'd4;
			default: wb_data = alu_result;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
			retire <= '0;
		end else begin
			if (instr_valid && rd_we)
				regs[rd] <= wb_data;
			retire.valid <= instr_valid;
			if (instr_valid)
				retire <= '{valid: 1'b1, pc: pc, rd_we: rd_we, rd: rd, data: wb_data};
		end
	end

	a_x0_zero: assert property (@(posedge clk) disable iff (reset) regs[0] == '0)
		else $error("regfile: x0 holds a nonzero value");

endmodule

// ==== logic/rv_data_mem.sv ====
`timescale 1ns/1ns

module rv_data_mem import rv_pkg::*; (
	input  logic  clk,
	input  logic  instr_valid,
	input  ctrl_t ctrl,
	input  word_t alu_result,
	input  word_t rs2_data,
	output word_t load_data
);

	word_t                  mem [DMEM_WORDS];
	logic [DMEM_AW-3:0]     idx;
	logic [1:0]             offs;
	logic [3:0]             byte_en;
	word_t                  wdata;
	word_t                  rd_word;
	word_t                  lane_word;

	assign idx  = alu_result[DMEM_AW-1:2];
	assign offs = alu_result[1:0];

	// Replicate the store data so every lane sees its byte
	always_comb begin
		case (ctrl.mask)
			F3_B: begin
				byte_en = 4'b0001 << offs;
				wdata   = {4{rs2_data[7:0]}};
			end
			F3_H: begin
				byte_en = offs[1] ? 4'b1100 : 4'b0011;
				wdata   = {2{rs2_data[15:0]}};
			end
			F3_W: begin
				byte_en = 4'b1111;
				wdata   = rs2_data;
			end
			default: begin
				byte_en = 4'b0000;
				wdata   = rs2_data;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (instr_valid && ctrl.wr_en) begin
			for (int i = 0; i < 4; i++)
				if (byte_en[i])
					mem[idx][i*8 +: 8] <= wdata[i*8 +: 8];
		end
	end

	assign rd_word   = mem[idx];
	assign lane_word = rd_word >> {offs, 3'b000}; // Addressed lane to bit 0

	always_comb begin
		load_data = '0;
		if (ctrl.rd_en) begin
			case (ctrl.mask)
				F3_B:    load_data = {{24{lane_word[7]}}, lane_word[7:0]};
				F3_H:    load_data = {{16{lane_word[15]}}, lane_word[15:0]};
				F3_BU:   load_data = {24'b0, lane_word[7:0]};
				F3_HU:   load_data = {16'b0, lane_word[15:0]};
				default: load_data = rd_word;
			endcase
		end
	end

	// Decoder only raises wr_en for valid store sizes
	a_store_lanes: assert property (@(posedge clk) (instr_valid && ctrl.wr_en) |-> byte_en != '0)
		else $error("data_mem: store with no byte lane");

endmodule

// ==== logic/rv_core.sv ====
`timescale 1ns/1ns

module rv_core import rv_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    instr_valid,
	input  word_t   instr,
	output word_t   pc,
	output retire_t retire
);

	ctrl_t ctrl;
	word_t rs1_data;
	word_t rs2_data;
	word_t alu_result; // Memory address for loads and stores
	word_t load_data;

	rv_decoder u_decoder (
		.instr (instr),
		.ctrl  (ctrl)
	);

	rv_alu u_alu (
		.ctrl       (ctrl),
		.rs1_data   (rs1_data),
		.rs2_data   (rs2_data),
		.pc         (pc),
		.alu_result (alu_result)
	);

	rv_pc_unit u_pc_unit (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.ctrl        (ctrl),
		.rs1_data    (rs1_data),
		.rs2_data    (rs2_data),
		.pc          (pc)
	);

	rv_regfile u_regfile (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.ctrl        (ctrl),
		.alu_result  (alu_result),
		.load_data   (load_data),
		.pc          (pc),
		.rs1_data    (rs1_data),
		.rs2_data    (rs2_data),
		.retire      (retire)
	);

	rv_data_mem u_data_mem (
		.clk         (clk),
		.instr_valid (instr_valid),
		.ctrl        (ctrl),
		.alu_result  (alu_result),
		.rs2_data    (rs2_data),
		.load_data   (load_data)
	);

endmodule

// ==== dv/tb_rv_core.sv ====
`timescale 1ns/1ns

module tb_rv_core import rv_pkg::*; ();

	localparam int FILL_INSTRS  = 3 * DMEM_WORDS;
	localparam int DIRECTED_MAX = 100;
	localparam int RAND_INSTRS  = 2000;
	localparam int MAX_GAP      = 4;
	localparam int INSTR_COUNT  = FILL_INSTRS + DIRECTED_MAX + RAND_INSTRS;
	localparam int IDLE_COUNT   = RAND_INSTRS * MAX_GAP + 16;
	localparam int WATCHDOG_NS  = (INSTR_COUNT + IDLE_COUNT + 20) * 4 * 2;

	localparam logic [2:0] LD_LIST [5] = '{F3_B, F3_H, F3_W, F3_BU, F3_HU};
	localparam logic [2:0] ST_LIST [3] = '{F3_B, F3_H, F3_W};
	localparam logic [2:0] BR_LIST [6] = '{BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU};
	localparam logic [6:0] OPC_NONE    = 7'b0010111; // AUIPC lies outside the subset

	logic    clk;
	logic    reset;
	logic    instr_valid;
	word_t   instr;
	word_t   dut_pc;
	retire_t dut_retire;

	// Reference state
	word_t      model_regs [32];
	logic [7:0] model_mem [DMEM_BYTES];
	word_t      model_pc;
	word_t      lfsr_state = 32'h6d7b_8c4a;
	retire_t    exp_q [$];
	word_t      exp_pc_q [$];
	int         value_errors = 0;
	int         other_errors = 0;

	rv_core u_dut (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (dut_pc),
		.retire      (dut_retire)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Fibonacci LFSR with taps 32 22 2 1 and one step per bit
	function automatic word_t take_bits(input int n);
		word_t v;
		logic  fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
		input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd);
		return {f7, rs2, rs1, f3, rd, OPC_R};
	endfunction

	function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
		input logic [2:0] f3, input reg_addr_t rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
		input reg_addr_t rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_S};
	endfunction

	function automatic word_t enc_b(input logic [12:0] imm, input reg_addr_t rs2,
		input reg_addr_t rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_B};
	endfunction

	function automatic word_t enc_u(input logic [19:0] imm, input reg_addr_t rd);
		return {imm, rd, OPC_U};
	endfunction

	function automatic word_t enc_j(input logic [20:0] imm, input reg_addr_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_J};
	endfunction

	function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
		input logic is_r, input word_t x, input word_t y);
		word_t fill;
		fill = x[31] ? ~(32'hffff_ffff >> y[4:0]) : 32'h0; // Sign bits for sra
		case (f3)
			3'b000:  return (is_r && alt) ? x - y : x + y;
			3'b001:  return x << y[4:0];
			3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
			3'b011:  return (x < y) ? 32'd1 : 32'd0;
			3'b100:  return x ^ y;
			3'b101:  return alt ? ((x >> y[4:0]) | fill) : (x >> y[4:0]);
			3'b110:  return x | y;
			default: return x & y;
		endcase
	endfunction

	// Executes one instruction on the model, returns retire and advances the pc
	function automatic void ref_exec(inout word_t r [32], inout logic [7:0] m [DMEM_BYTES],
		inout word_t cur_pc, input word_t ins, output retire_t ex);
		word_t      a;
		word_t      b;
		word_t      imm_i;
		word_t      imm_s;
		word_t      imm_b;
		word_t      imm_j;
		word_t      res;
		word_t      addr;
		word_t      nxt;
		logic [2:0] f3;
		logic       alt;
		logic       we;
		logic       tk;
		int         ba;
		a     = r[ins[19:15]];
		b     = r[ins[24:20]];
		f3    = ins[14:12];
		alt   = (ins[31:25] == FUNCT7_ALT);
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		res   = '0;
		we    = 1'b0;
		tk    = 1'b0;
		nxt   = cur_pc + 32'd4;
		case (ins[6:0])
			OPC_R: begin
				we  = 1'b1;
				res = alu_ref(f3, alt, 1'b1, a, b);
			end
			OPC_I: begin
				we  = 1'b1;
				res = alu_ref(f3, alt, 1'b0, a, imm_i);
			end
			OPC_U: begin
				we  = 1'b1;
				res = {ins[31:12], 12'h000};
			end
			OPC_L: begin
				addr = a + imm_i;
				ba   = int'(addr[9:0]);
				we   = 1'b1;
				case (f3)
					F3_B:    res = {{24{m[ba][7]}}, m[ba]};
					F3_H:    res = {{16{m[ba+1][7]}}, m[ba+1], m[ba]};
					F3_W:    res = {m[ba+3], m[ba+2], m[ba+1], m[ba]};
					F3_BU:   res = {24'h0, m[ba]};
					F3_HU:   res = {16'h0, m[ba+1], m[ba]};
					default: we = 1'b0;
				endcase
			end
			OPC_S: begin
				addr = a + imm_s;
				ba   = int'(addr[9:0]);
				if (f3 == F3_B || f3 == F3_H || f3 == F3_W)
					m[ba] = b[7:0];
				if (f3 == F3_H || f3 == F3_W)
					m[ba+1] = b[15:8];
				if (f3 == F3_W) begin
					m[ba+2] = b[23:16];
					m[ba+3] = b[31:24];
				end
			end
			OPC_B: begin
				case (f3)
					BR_EQ:   tk = (a == b);
					BR_NE:   tk = (a != b);
					BR_LT:   tk = ($signed(a) < $signed(b));
					BR_GE:   tk = !($signed(a) < $signed(b));
					BR_LTU:  tk = (a < b);
					BR_GEU:  tk = !(a < b);
					default: tk = 1'b0;
				endcase
				if (tk)
					nxt = cur_pc + imm_b;
			end
			OPC_J: begin
				we  = 1'b1;
				res = cur_pc + 32'd4; // Link
				nxt = cur_pc + imm_j;
			end
			default: ;
		endcase
		if (ins[11:7] == 5'd0)
			we = 1'b0;
		if (we)
			r[ins[11:7]] = res;
		ex = '{valid: 1'b1, pc: cur_pc, rd_we: we, rd: ins[11:7], data: res};
		cur_pc = nxt;
	endfunction

	function automatic word_t rand_instr();
		logic [2:0] cls;
		logic [2:0] f3;
		logic [6:0] f7;
		logic [3:0] offs;
		logic [9:0] addr;
		reg_addr_t  rd;
		reg_addr_t  rs1;
		reg_addr_t  rs2;
		cls  = 3'(take_bits(3));
		rd   = 5'(take_bits(5));
		rs1  = 5'(take_bits(5));
		rs2  = 5'(take_bits(5));
		f3   = 3'(take_bits(3));
		f7   = (take_bits(1) == 32'd1) ? FUNCT7_ALT : 7'b0;
		offs = 4'(take_bits(4)); // Branch and jump offset in words
		addr = 10'(take_bits(10));
		case (cls)
			3'd0, 3'd1: begin
				if (f3 != 3'b000 && f3 != 3'b101)
					f7 = 7'b0;
				return enc_r(f7, rs2, rs1, f3, rd);
			end
			3'd2: begin
				if (f3 == 3'b001)
					return enc_i({7'b0, rs2}, rs1, f3, rd, OPC_I);
				if (f3 == 3'b101)
					return enc_i({f7, rs2}, rs1, f3, rd, OPC_I);
				return enc_i(12'(take_bits(12)), rs1, f3, rd, OPC_I);
			end
			3'd3: return enc_u(20'(take_bits(20)), rd);
			3'd4: begin
				f3 = LD_LIST[int'(take_bits(3) % 5)];
				if (f3 != F3_B && f3 != F3_BU)
					addr[0] = 1'b0;
				if (f3 == F3_W)
					addr[1] = 1'b0;
				return enc_i({2'b00, addr}, 0, f3, rd, OPC_L);
			end
			3'd5: begin
				f3 = ST_LIST[int'(take_bits(2) % 3)];
				if (f3 != F3_B)
					addr[0] = 1'b0;
				if (f3 == F3_W)
					addr[1] = 1'b0;
				return enc_s({2'b00, addr}, rs2, 0, f3);
			end
			3'd6: begin
				f3 = BR_LIST[int'(take_bits(3) % 6)];
				return enc_b({{7{offs[3]}}, offs, 2'b00}, rs2, rs1, f3);
			end
			default: begin
				if (take_bits(1) == 32'd1)
					return enc_j({{15{offs[3]}}, offs, 2'b00}, rd);
				return {20'(take_bits(20)), rd, OPC_NONE};
			end
		endcase
	endfunction

	function automatic void check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("CHECK FAILED %s got %h exp %h at %0t", name, got, exp, $time);
		end
	endfunction

	task automatic issue(input word_t ins);
		retire_t ex;
		@(negedge clk);
		ref_exec(model_regs, model_mem, model_pc, ins, ex);
		instr_valid = 1'b1;
		instr       = ins;
		exp_q.push_back(ex);
		exp_pc_q.push_back(model_pc);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk);
			instr_valid = 1'b0;
			instr       = take_bits(32); // Garbage that must be ignored
			exp_q.push_back('0);
			exp_pc_q.push_back(model_pc);
		end
	endtask

	// Compares the DUT after each edge against the queued expectation
	initial begin
		retire_t ex;
		word_t   ep;
		forever begin
			@(posedge clk);
			#1;
			if (exp_q.size() > 0) begin
				ex = exp_q.pop_front();
				ep = exp_pc_q.pop_front();
				check_word("retire.valid", 32'(dut_retire.valid), 32'(ex.valid));
				if (ex.valid) begin
					check_word("retire.pc", dut_retire.pc, ex.pc);
					check_word("retire.rd_we", 32'(dut_retire.rd_we), 32'(ex.rd_we));
				end
				if (ex.rd_we) begin
					check_word("retire.rd", 32'(dut_retire.rd), 32'(ex.rd));
					check_word("retire.data", dut_retire.data, ex.data);
				end
				check_word("pc", dut_pc, ep);
			end else if (!reset && dut_retire.valid) begin
				other_errors++;
				$display("Retire reported with no instruction issued at %0t", $time);
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		other_errors++;
		$display("Timeout after %0d ns, instruction stream did not drain", WATCHDOG_NS);
		$display("value errors %0d, other errors %0d", value_errors, other_errors);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		reset       = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		model_pc    = '0;
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		for (int i = 0; i < DMEM_BYTES; i++)
			model_mem[i] = '0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_word("pc", dut_pc, '0);
		check_word("retire.valid", 32'(dut_retire.valid), 32'h0);

		// Fill every word so later loads never see uninitialized memory
		for (int i = 0; i < DMEM_WORDS; i++) begin
			issue(enc_u(20'(i * 40503 + 1), 5));
			issue(enc_i({1'b0, 8'(i), 3'b101}, 5, 3'b000, 5, OPC_I));
			issue(enc_s(12'(i * 4), 5, 0, F3_W));
		end

		issue(enc_u(20'h80000, 1));
		issue(enc_i(12'h005, 1, 3'b000, 1, OPC_I)); // x1 = 0x80000005
		issue(enc_i(12'hffd, 0, 3'b000, 2, OPC_I)); // x2 = -3
		issue(enc_i(12'h007, 0, 3'b000, 3, OPC_I)); // x3 = 7
		for (int f = 0; f < 8; f++)
			issue(enc_r(7'b0, 3, 1, 3'(f), 5'(4 + f)));
		issue(enc_r(FUNCT7_ALT, 2, 3, 3'b000, 12)); // sub
		issue(enc_r(FUNCT7_ALT, 3, 1, 3'b101, 13)); // sra
		for (int f = 0; f < 8; f++)
			issue(enc_i((f == 1) ? 12'h004 : (f == 5) ? 12'h404 : 12'hffd, 2, 3'(f),
				5'(14 + f), OPC_I));
		issue(enc_i(12'h004, 1, 3'b101, 22, OPC_I)); // srli
		issue(enc_u(20'h12345, 23));

		// Stores to several lanes, then loads of every size
		issue(enc_s(12'h100, 1, 0, F3_W));
		issue(enc_s(12'h105, 3, 0, F3_B));
		issue(enc_s(12'h107, 2, 0, F3_B));
		issue(enc_s(12'h10a, 2, 0, F3_H));
		issue(enc_s(12'h108, 3, 0, F3_H));
		issue(enc_i(12'h107, 0, F3_B, 24, OPC_L));
		issue(enc_i(12'h107, 0, F3_BU, 25, OPC_L));
		issue(enc_i(12'h105, 0, F3_B, 26, OPC_L));
		issue(enc_i(12'h10a, 0, F3_H, 27, OPC_L));
		issue(enc_i(12'h10a, 0, F3_HU, 28, OPC_L));
		issue(enc_i(12'h102, 0, F3_H, 29, OPC_L));
		issue(enc_i(12'h102, 0, F3_HU, 30, OPC_L));
		issue(enc_i(12'h104, 0, F3_W, 31, OPC_L));
		issue(enc_i(12'h108, 0, F3_W, 24, OPC_L));

		// Operand pairs give each branch both outcomes
		for (int f = 0; f < 6; f++) begin
			issue(enc_b(13'd12, 3, 1, BR_LIST[f]));
			issue(enc_b(13'h1ff8, 1, 3, BR_LIST[f]));
			issue(enc_b(13'd8, 3, 3, BR_LIST[f]));
		end
		issue(enc_j(21'd16, 25));
		issue(enc_j(21'h1ffff8, 0));

		issue(enc_i(12'h005, 0, 3'b000, 0, OPC_I));
		issue(enc_r(7'b0, 3, 1, 3'b000, 0));
		issue(enc_u(20'hfffff, 0));
		issue(enc_r(7'b0, 0, 0, 3'b000, 26)); // x0 + x0 must be zero
		idle(3);

		for (int n = 0; n < RAND_INSTRS; n++) begin
			issue(rand_instr());
			if (take_bits(2) == 32'd0)
				idle(1 + int'(take_bits(2)));
		end
		idle(2);
		while (exp_q.size() != 0)
			@(posedge clk);
		@(negedge clk);

		$display("value errors %0d, other errors %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
logic/rv_pkg.sv
logic/rv_decoder.sv
logic/rv_alu.sv
logic/rv_pc_unit.sv
logic/rv_regfile.sv
logic/rv_data_mem.sv
logic/rv_core.sv
dv/tb_rv_core.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_rv_core -f filelist.f -o sim_tb_rv_core
./obj_dir/sim_tb_rv_core | tee sim.log

# Pass only if the pass line is in the log
grep -q "^NO ERRORS$" sim.log
